// File: src/ctl_pkg.sv
// Shared widths, register map and constants for the settings controller.
// The control page is 128 words. Only the addresses below are used.
// The channel count sets the width of the delay table index.
`default_nettype none

package ctl_pkg;

  localparam int NUM_CH   = 8;
  localparam int PAGE_BIT = 8;   // host address bit, 0 = control, 1 = delay.

  typedef logic [15:0]                 word_t;
  typedef logic [6:0]                  reg_addr_t;
  typedef logic [$clog2(NUM_CH)-1:0]   ch_idx_t;
  typedef logic [63:0]                 sync_time_t;
  typedef logic [8:0]                  step_t;

  // control page map.
  localparam reg_addr_t ADDR_CTL_FLAG    = 7'h00;
  localparam reg_addr_t ADDR_VERSION     = 7'h01;
  localparam reg_addr_t ADDR_STATUS      = 7'h02;
  localparam reg_addr_t ADDR_CYCLE       = 7'h10;
  localparam reg_addr_t ADDR_FREQ_DIV_0  = 7'h11;   // low half.
  localparam reg_addr_t ADDR_FREQ_DIV_1  = 7'h12;
  localparam reg_addr_t ADDR_STEP        = 7'h13;
  localparam reg_addr_t ADDR_SYNC_TIME_0 = 7'h20;   // lowest word.
  localparam reg_addr_t ADDR_SYNC_TIME_1 = 7'h21;
  localparam reg_addr_t ADDR_SYNC_TIME_2 = 7'h22;
  localparam reg_addr_t ADDR_SYNC_TIME_3 = 7'h23;

  // bits of the flag word.
  localparam int FLAG_OP_MODE_BIT   = 0;
  localparam int FLAG_FORCE_FAN_BIT = 4;
  localparam int FLAG_SYNC_BIT      = 8;   // self-clearing, set by host.

  localparam word_t VERSION_WORD = 16'h0103;

endpackage

`default_nettype wire

// File: src/ctl_port_if.sv
// Sequencer side of the control register RAM.
// Read data arrives two edges after the address is set. No handshake.
`timescale 1ns/100ps
`default_nettype none

interface ctl_port_if import ctl_pkg::*; ();

  reg_addr_t addr;
  logic      we;
  word_t     wdata;
  word_t     rdata;   // registered in the RAM.

  modport seq (
    output addr,
    output we,
    output wdata,
    input  rdata
  );

  modport ram (
    input  addr,
    input  we,
    input  wdata,
    output rdata
  );

endinterface

`default_nettype wire

// File: src/ctl_regfile.sv
// Control register RAM with a host port and a sequencer port.
// Both ports read first and register their output.
// A write from both ports to one address in one cycle keeps the host word.
// Contents are not cleared by reset.
`timescale 1ns/100ps
`default_nettype none

module ctl_regfile import ctl_pkg::*; (
  input  wire        CLK,
  input  logic       host_en,
  input  logic       host_we,
  input  reg_addr_t  host_addr,
  input  word_t      host_wdata,
  output word_t      host_rdata,
  ctl_port_if.ram    ctl_port
);

  localparam int DEPTH = 2 ** $bits(reg_addr_t);

  word_t mem [DEPTH];

  always_ff @(posedge CLK) begin
    if (ctl_port.we) begin
      mem[ctl_port.addr] <= ctl_port.wdata;
    end
    // host last, so it wins a collision.
    if (host_en && host_we) begin
      mem[host_addr] <= host_wdata;
    end
  end

  always_ff @(posedge CLK) begin
    if (host_en) begin
      host_rdata <= mem[host_addr];
    end
  end

  always_ff @(posedge CLK) begin
    ctl_port.rdata <= mem[ctl_port.addr];   // sequencer reads every cycle.
  end

endmodule

`default_nettype wire

// File: src/ctl_sequencer.sv
// Walks the control page in a fixed loop and latches settings onto ports.
// Writes the version word once after reset and the status word every loop.
// thermo is sampled as is, so it must already be synchronous to CLK.
// A host write to the flag word during a sync write-back may be lost.
`timescale 1ns/100ps
`default_nettype none

module ctl_sequencer import ctl_pkg::*; (
  input  wire         CLK,
  input  wire         rst_n,
  input  logic        thermo,
  ctl_port_if.seq     ctl_port,
  output logic        force_fan,
  output logic        op_mode,
  output logic        sync_set,
  output word_t       cycle,
  output logic [31:0] freq_div,
  output step_t       step,
  output sync_time_t  sync_time
);

  // each name gives the word captured now, then the request issued now.
  typedef enum logic [3:0] {
    REQ_WR_VER,
    REQ_RD_FLAG,
    REQ_RD_CYCLE,
    RD_FLAG_REQ_DIV_0,
    RD_CYCLE_REQ_DIV_1,
    RD_DIV_0_REQ_STEP,
    RD_DIV_1_REQ_WR_STATUS,
    RD_STEP_REQ_FLAG,
    REQ_RD_SYNC_0,
    REQ_RD_SYNC_1,
    RD_SYNC_0_REQ_SYNC_2,
    RD_SYNC_1_REQ_SYNC_3,
    RD_SYNC_2_REQ_FLAG,
    RD_SYNC_3_REQ_CYCLE
  } seq_state_t;

  seq_state_t state;
  word_t      flag_q;

  assign force_fan = flag_q[FLAG_FORCE_FAN_BIT];
  assign op_mode   = flag_q[FLAG_OP_MODE_BIT];

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      state         <= REQ_WR_VER;
      ctl_port.we   <= 1'b0;
      ctl_port.addr <= '0;
      flag_q        <= '0;
      cycle         <= '0;
      freq_div      <= '0;
      step          <= '0;
      sync_time     <= '0;
      sync_set      <= 1'b0;
    end else begin
      case (state)
        REQ_WR_VER: begin
          ctl_port.we    <= 1'b1;
          ctl_port.addr  <= ADDR_VERSION;
          ctl_port.wdata <= VERSION_WORD;
          state          <= REQ_RD_FLAG;
        end
        REQ_RD_FLAG: begin
          ctl_port.we   <= 1'b0;
          ctl_port.addr <= ADDR_CTL_FLAG;
          state         <= REQ_RD_CYCLE;
        end
        REQ_RD_CYCLE: begin
          ctl_port.addr <= ADDR_CYCLE;   // speculative, dropped on sync.
          state         <= RD_FLAG_REQ_DIV_0;
        end
        RD_FLAG_REQ_DIV_0: begin
          flag_q <= ctl_port.rdata;
          if (ctl_port.rdata[FLAG_SYNC_BIT]) begin
            // write back with the sync bit cleared.
            ctl_port.we    <= 1'b1;
            ctl_port.addr  <= ADDR_CTL_FLAG;
            ctl_port.wdata <= ctl_port.rdata & ~(word_t'(1) << FLAG_SYNC_BIT);
            state          <= REQ_RD_SYNC_0;
          end else begin
            ctl_port.addr <= ADDR_FREQ_DIV_0;
            state         <= RD_CYCLE_REQ_DIV_1;
          end
        end
        RD_CYCLE_REQ_DIV_1: begin
          cycle         <= ctl_port.rdata;
          ctl_port.addr <= ADDR_FREQ_DIV_1;
          state         <= RD_DIV_0_REQ_STEP;
        end
        RD_DIV_0_REQ_STEP: begin
          freq_div[15:0] <= ctl_port.rdata;
          ctl_port.addr  <= ADDR_STEP;
          state          <= RD_DIV_1_REQ_WR_STATUS;
        end
        RD_DIV_1_REQ_WR_STATUS: begin
          freq_div[31:16] <= ctl_port.rdata;
          ctl_port.we     <= 1'b1;
          ctl_port.addr   <= ADDR_STATUS;
          ctl_port.wdata  <= {{($bits(word_t) - 1){1'b0}}, thermo};
          state           <= RD_STEP_REQ_FLAG;
        end
        RD_STEP_REQ_FLAG: begin
          step          <= ctl_port.rdata[$bits(step_t)-1:0];   // upper bits dropped.
          ctl_port.we   <= 1'b0;
          ctl_port.addr <= ADDR_CTL_FLAG;
          state         <= REQ_RD_CYCLE;
        end
        REQ_RD_SYNC_0: begin
          ctl_port.we   <= 1'b0;
          ctl_port.addr <= ADDR_SYNC_TIME_0;
          state         <= REQ_RD_SYNC_1;
        end
        REQ_RD_SYNC_1: begin
          ctl_port.addr <= ADDR_SYNC_TIME_1;
          state         <= RD_SYNC_0_REQ_SYNC_2;
        end
        RD_SYNC_0_REQ_SYNC_2: begin
          sync_time[15:0] <= ctl_port.rdata;
          ctl_port.addr   <= ADDR_SYNC_TIME_2;
          state           <= RD_SYNC_1_REQ_SYNC_3;
        end
        RD_SYNC_1_REQ_SYNC_3: begin
          sync_time[31:16] <= ctl_port.rdata;
          ctl_port.addr    <= ADDR_SYNC_TIME_3;
          state            <= RD_SYNC_2_REQ_FLAG;
        end
        RD_SYNC_2_REQ_FLAG: begin
          sync_time[47:32] <= ctl_port.rdata;
          ctl_port.addr    <= ADDR_CTL_FLAG;   // reread after the clear.
          state            <= RD_SYNC_3_REQ_CYCLE;
        end
        RD_SYNC_3_REQ_CYCLE: begin
          sync_time[63:48] <= ctl_port.rdata;
          sync_set         <= 1'b1;   // sticky until reset.
          ctl_port.addr    <= ADDR_CYCLE;
          state            <= RD_FLAG_REQ_DIV_0;
        end
        default: begin
          state <= REQ_WR_VER;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: src/table_scan_counter.sv
// Index pair for the delay table scan, one step per cycle.
// set_idx is one behind rd_idx to cover the registered RAM read.
`timescale 1ns/100ps
`default_nettype none

module table_scan_counter import ctl_pkg::*; (
  input  wire      CLK,
  input  wire      rst_n,
  output ch_idx_t  rd_idx,
  output ch_idx_t  set_idx
);

  localparam ch_idx_t LAST_IDX = ch_idx_t'(NUM_CH - 1);

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      rd_idx  <= '0;
      set_idx <= LAST_IDX;
    end else begin
      rd_idx  <= (rd_idx == LAST_IDX) ? '0 : rd_idx + 1'b1;
      set_idx <= (set_idx == LAST_IDX) ? '0 : set_idx + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: src/delay_table.sv
// Per-channel delay RAM, written by the host and read by the scan.
// Each word read is copied into the shadow entry given by set_idx.
// No reset: entries are undefined until the host writes them.
`timescale 1ns/100ps
`default_nettype none

module delay_table import ctl_pkg::*; (
  input  wire      CLK,
  input  logic     wr_en,
  input  ch_idx_t  wr_idx,
  input  word_t    wdata,
  input  ch_idx_t  rd_idx,
  input  ch_idx_t  set_idx,
  output word_t    delay_out [NUM_CH]
);

  word_t mem [NUM_CH];
  word_t rd_word;

  always_ff @(posedge CLK) begin
    if (wr_en) begin
      mem[wr_idx] <= wdata;
    end
  end

  always_ff @(posedge CLK) begin
    rd_word <= mem[rd_idx];   // read first on a collision.
  end

  // shadow copy, one entry per cycle.
  always_ff @(posedge CLK) begin
    delay_out[set_idx] <= rd_word;
  end

endmodule

`default_nettype wire

// File: src/ctl_top.sv
// Settings controller top. Host bus is a plain strobe bus on CLK.
// Host address bit PAGE_BIT picks the page. The delay page is write-only,
// so cpu_rdata always comes from the control page, one cycle after cpu_en.
`timescale 1ns/100ps
`default_nettype none

module ctl_top import ctl_pkg::*; (
  input  wire                CLK,
  input  wire                rst_n,
  input  logic               thermo,
  input  logic               cpu_en,
  input  logic               cpu_we,
  input  logic [PAGE_BIT:0]  cpu_addr,
  input  word_t              cpu_wdata,
  output word_t              cpu_rdata,
  output logic               force_fan,
  output logic               op_mode,
  output logic               sync_set,
  output word_t              cycle,
  output logic [31:0]        freq_div,
  output step_t              step,
  output sync_time_t         sync_time,
  output word_t              delay_out [NUM_CH]
);

  logic    ctl_en;
  logic    dly_we;
  ch_idx_t rd_idx;
  ch_idx_t set_idx;

  assign ctl_en = cpu_en & ~cpu_addr[PAGE_BIT];
  assign dly_we = cpu_en & cpu_addr[PAGE_BIT] & cpu_we;

  ctl_port_if ctl_bus ();

  ctl_regfile u_regfile (
    .CLK        (CLK),
    .host_en    (ctl_en),
    .host_we    (cpu_we),
    .host_addr  (cpu_addr[$bits(reg_addr_t)-1:0]),
    .host_wdata (cpu_wdata),
    .host_rdata (cpu_rdata),
    .ctl_port   (ctl_bus)
  );

  ctl_sequencer u_sequencer (
    .CLK       (CLK),
    .rst_n     (rst_n),
    .thermo    (thermo),
    .ctl_port  (ctl_bus),
    .force_fan (force_fan),
    .op_mode   (op_mode),
    .sync_set  (sync_set),
    .cycle     (cycle),
    .freq_div  (freq_div),
    .step      (step),
    .sync_time (sync_time)
  );

  table_scan_counter u_scan (
    .CLK     (CLK),
    .rst_n   (rst_n),
    .rd_idx  (rd_idx),
    .set_idx (set_idx)
  );

  delay_table u_delay (
    .CLK       (CLK),
    .wr_en     (dly_we),
    .wr_idx    (cpu_addr[$bits(ch_idx_t)-1:0]),   // upper page bits ignored.
    .wdata     (cpu_wdata),
    .rd_idx    (rd_idx),
    .set_idx   (set_idx),
    .delay_out (delay_out)
  );

endmodule

`default_nettype wire

// File: bench/tb_ctl_top.sv
// Directed testbench for the settings controller top.
// Stops at the first failing check or timeout.
// Control RAM is not cleared, so every test writes what it later checks.
`timescale 1ns/100ps
`default_nettype none

module tb_ctl_top import ctl_pkg::*; ();

  localparam int TIMEOUT   = 64;
  localparam int SEL_DELAY = 8;   // output selector base for delay_out entries.

  logic              CLK;
  logic              rst_n;
  logic              thermo;
  logic              cpu_en;
  logic              cpu_we;
  logic [PAGE_BIT:0] cpu_addr;
  word_t             cpu_wdata;
  word_t             cpu_rdata;
  logic              force_fan;
  logic              op_mode;
  logic              sync_set;
  word_t             cycle;
  logic [31:0]       freq_div;
  step_t             step;
  sync_time_t        sync_time;
  word_t             delay_out [NUM_CH];

  integer            seed;
  word_t             dly_words [NUM_CH];

  ctl_top UUT (
    .CLK       (CLK),
    .rst_n     (rst_n),
    .thermo    (thermo),
    .cpu_en    (cpu_en),
    .cpu_we    (cpu_we),
    .cpu_addr  (cpu_addr),
    .cpu_wdata (cpu_wdata),
    .cpu_rdata (cpu_rdata),
    .force_fan (force_fan),
    .op_mode   (op_mode),
    .sync_set  (sync_set),
    .cycle     (cycle),
    .freq_div  (freq_div),
    .step      (step),
    .sync_time (sync_time),
    .delay_out (delay_out)
  );

  always #4 CLK = ~CLK;   // 8 ns period.

  function automatic logic [PAGE_BIT:0] ctl_addr(input reg_addr_t a);
    return {2'b00, a};
  endfunction

  function automatic logic [PAGE_BIT:0] dly_addr(input int idx);
    return (1 << PAGE_BIT) | idx;
  endfunction

  function automatic logic [63:0] read_output(input int sel);
    logic [63:0] val;
    case (sel)
      0: val = cycle;
      1: val = freq_div;
      2: val = step;
      3: val = {force_fan, op_mode};
      4: val = sync_set;
      5: val = sync_time;
      default: val = delay_out[sel - SEL_DELAY];
    endcase
    return val;
  endfunction

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped at first failure");
  endtask

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      stop_run($sformatf("[ERROR] %s: got 0x%0h, expected 0x%0h", name, actual, expected));
    end
  endtask

  task automatic wait_for_value(input int sel, input logic [63:0] expected, input string name);
    int cycles;
    cycles = 0;
    while (read_output(sel) !== expected && cycles < TIMEOUT) begin
      @(negedge CLK);
      cycles++;
    end
    if (read_output(sel) !== expected) begin
      stop_run($sformatf("timeout: %s never reached 0x%0h within %0d cycles",
                         name, expected, TIMEOUT));
    end
  endtask

  // called on a falling edge, returns on a falling edge.
  task automatic bus_write(input logic [PAGE_BIT:0] addr, input word_t data);
    cpu_en    = 1'b1;
    cpu_we    = 1'b1;
    cpu_addr  = addr;
    cpu_wdata = data;
    @(negedge CLK);
    cpu_en = 1'b0;
    cpu_we = 1'b0;
  endtask

  task automatic bus_read(input logic [PAGE_BIT:0] addr, output word_t data);
    cpu_en   = 1'b1;
    cpu_we   = 1'b0;
    cpu_addr = addr;
    @(negedge CLK);
    data   = cpu_rdata;   // registered one edge after the request.
    cpu_en = 1'b0;
  endtask

  task automatic poll_status(input logic expected_bit);
    word_t data;
    int    reads;
    reads = 0;
    bus_read(ctl_addr(ADDR_STATUS), data);
    while (data[0] !== expected_bit && reads < TIMEOUT) begin
      bus_read(ctl_addr(ADDR_STATUS), data);
      reads++;
    end
    check_value("status[0]", data[0], expected_bit);
  endtask

  task automatic test_version();
    word_t data;
    repeat (4) @(negedge CLK);   // version is written within 4 cycles.
    bus_read(ctl_addr(ADDR_VERSION), data);
    check_value("version", data, VERSION_WORD);
    check_value("sync_set", sync_set, 1'b0);
  endtask

  task automatic test_settings();
    word_t flag_wr;
    bus_write(ctl_addr(ADDR_CYCLE), 16'h1234);
    bus_write(ctl_addr(ADDR_FREQ_DIV_0), 16'hbeef);
    bus_write(ctl_addr(ADDR_FREQ_DIV_1), 16'h0042);
    bus_write(ctl_addr(ADDR_STEP), 16'hf1a5);   // upper bits must drop.
    // fan bit alone first, so the two flag outputs cannot be swapped.
    bus_write(ctl_addr(ADDR_CTL_FLAG), 16'h1 << FLAG_FORCE_FAN_BIT);
    wait_for_value(3, 64'h2, "{force_fan, op_mode}");
    flag_wr = (16'h1 << FLAG_OP_MODE_BIT) | (16'h1 << FLAG_FORCE_FAN_BIT);
    bus_write(ctl_addr(ADDR_CTL_FLAG), flag_wr);
    wait_for_value(0, 64'h1234, "cycle");
    wait_for_value(1, 64'h0042_beef, "freq_div");
    wait_for_value(2, 64'h1a5, "step");
    wait_for_value(3, 64'h3, "{force_fan, op_mode}");
  endtask

  task automatic test_thermo();
    thermo = 1'b1;
    poll_status(1'b1);
    thermo = 1'b0;
    poll_status(1'b0);
  endtask

  task automatic test_sync();
    word_t      words [4];
    word_t      flag_wr;
    word_t      data;
    sync_time_t expected;
    for (int i = 0; i < 4; i++) begin
      words[i] = $random(seed);
      bus_write(ctl_addr(ADDR_SYNC_TIME_0 + i), words[i]);
    end
    expected = {words[3], words[2], words[1], words[0]};
    // sync bit must clear while op mode, fan and one spare bit stay.
    flag_wr = 16'h2011 | (16'h1 << FLAG_SYNC_BIT);
    bus_write(ctl_addr(ADDR_CTL_FLAG), flag_wr);
    wait_for_value(4, 64'h1, "sync_set");
    check_value("sync_time", sync_time, expected);
    bus_read(ctl_addr(ADDR_CTL_FLAG), data);
    check_value("flag word", data, 16'h2011);
  endtask

  task automatic test_delay();
    for (int i = 0; i < NUM_CH; i++) begin
      dly_words[i] = $random(seed);
      bus_write(dly_addr(i), dly_words[i]);
    end
    for (int i = 0; i < NUM_CH; i++) begin
      wait_for_value(SEL_DELAY + i, dly_words[i], $sformatf("delay_out[%0d]", i));
    end
  endtask

  initial begin
    seed      = 32'hd3af_fc87;
    CLK       = 1'b0;
    rst_n     = 1'b0;
    thermo    = 1'b0;
    cpu_en    = 1'b0;
    cpu_we    = 1'b0;
    cpu_addr  = '0;
    cpu_wdata = '0;
    repeat (5) @(negedge CLK);
    rst_n = 1'b1;

    test_version();
    test_settings();
    test_thermo();
    test_sync();
    test_delay();

    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
src/ctl_pkg.sv
src/ctl_port_if.sv
src/ctl_regfile.sv
src/ctl_sequencer.sv
src/table_scan_counter.sv
src/delay_table.sv
src/ctl_top.sv
bench/tb_ctl_top.sv
